// File: rtl/snake_game_pkg.sv
package snake_game_pkg;

	////////////////////////////////////////
	// Play field grid
	////////////////////////////////////////

	typedef logic [5:0] coord_t;

	localparam coord_t FIELD_MIN = 6'd1;
	localparam coord_t FIELD_MAX = 6'd13;

	// Wall lines surround the field
	localparam coord_t WALL_LO = 6'd0;
	localparam coord_t WALL_HI = 6'd14;

	////////////////////////////////////////
	// Heading
	////////////////////////////////////////

	// Upper bit set means vertical
	typedef enum logic [1:0] {
		HEAD_RIGHT = 2'b00,
		HEAD_LEFT  = 2'b01,
		HEAD_UP    = 2'b10,
		HEAD_DOWN  = 2'b11
	} heading_t;

	////////////////////////////////////////
	// Game state
	////////////////////////////////////////

	localparam coord_t START_X = 6'd2;
	localparam coord_t START_Y = 6'd12;

	localparam coord_t APPLE_X = 6'd10;
	localparam coord_t APPLE_Y = 6'd10;

	// Head included
	localparam int MAX_LEN = 16;
	localparam int LEN_W = $clog2(MAX_LEN + 1);
	typedef logic [LEN_W-1:0] len_t;

	typedef logic [11:0] score_t;

	// One move every 25M cycles
	localparam int TICK_DEFAULT = 25_000_000;
	localparam int TICK_W = $clog2(TICK_DEFAULT + 1);
	typedef logic [TICK_W-1:0] tick_t;

endpackage

// File: rtl/video_pkg.sv
package video_pkg;

	////////////////////////////////////////
	// Scan and tile geometry
	////////////////////////////////////////

	localparam int SCAN_W = 12;

	// 32 pixel tiles
	localparam int TILE_BITS = 5;

	////////////////////////////////////////
	// Colour
	////////////////////////////////////////

	typedef logic [7:0] chan_t;

	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} rgb_t;

	localparam rgb_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};

	// Fill colours, outline is each channel halved
	localparam rgb_t WALL_FILL  = '{r: 8'hA0, g: 8'hA0, b: 8'hA0};
	localparam rgb_t SNAKE_FILL = '{r: 8'h20, g: 8'hD0, b: 8'h30};
	localparam rgb_t APPLE_FILL = '{r: 8'hE0, g: 8'h28, b: 8'h20};

	////////////////////////////////////////
	// Sprite kinds
	////////////////////////////////////////

	typedef enum logic [1:0] {
		SPR_NONE  = 2'd0,
		SPR_WALL  = 2'd1,
		SPR_SNAKE = 2'd2,
		SPR_APPLE = 2'd3
	} sprite_t;

endpackage

// File: rtl/heading_control.sv
`timescale 1ns/10ps

module heading_control (
	input  logic                      i_clk_74M,
	input  logic                      i_rst,
	input  logic                      i_btn_right,
	input  logic                      i_btn_left,
	input  logic                      i_btn_up,
	input  logic                      i_btn_down,
	output snake_game_pkg::heading_t  o_heading
);

	logic vertical;

	assign vertical = o_heading[1];

	// Only turns perpendicular to the current heading
	always_ff @(posedge i_clk_74M) begin
		if (i_rst) begin
			o_heading <= snake_game_pkg::HEAD_RIGHT;
		end else if (vertical && i_btn_right) begin
			o_heading <= snake_game_pkg::HEAD_RIGHT;
		end else if (vertical && i_btn_left) begin
			o_heading <= snake_game_pkg::HEAD_LEFT;
		end else if (!vertical && i_btn_down) begin
			o_heading <= snake_game_pkg::HEAD_DOWN;
		end else if (!vertical && i_btn_up) begin
			o_heading <= snake_game_pkg::HEAD_UP;
		end
	end

	// Any change must swap axis, never reverse in place
	property p_no_reversal;
		@(posedge i_clk_74M) disable iff (i_rst)
		(o_heading != $past(o_heading)) |-> (o_heading[1] != $past(o_heading[1]));
	endproperty

	a_no_reversal : assert property (p_no_reversal)
		else $error("heading reversed within one cycle");

endmodule

// File: rtl/snake_motion.sv
`timescale 1ns/10ps

module snake_motion #(
	parameter int TICK_CYCLES = snake_game_pkg::TICK_DEFAULT
) (
	input  logic                      i_clk_74M,
	input  logic                      i_rst,
	input  snake_game_pkg::heading_t  i_heading,
	output snake_game_pkg::coord_t    o_head_x,
	output snake_game_pkg::coord_t    o_head_y,
	output logic                      o_step,
	output logic                      o_grow,
	output snake_game_pkg::score_t    o_score
);

	snake_game_pkg::tick_t  tick_cnt;
	snake_game_pkg::coord_t nxt_x;
	snake_game_pkg::coord_t nxt_y;
	logic                   hit_apple;

	////////////////////////////////////////
	// Game tick
	////////////////////////////////////////

	assign o_step = (tick_cnt == snake_game_pkg::tick_t'(TICK_CYCLES - 1));

	always_ff @(posedge i_clk_74M) begin
		if (i_rst) begin
			tick_cnt <= '0;
		end else if (o_step) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Next head tile with wrap
	////////////////////////////////////////

	always_comb begin
		nxt_x = o_head_x;
		nxt_y = o_head_y;
		case (i_heading)
			snake_game_pkg::HEAD_RIGHT:
				nxt_x = (o_head_x >= snake_game_pkg::FIELD_MAX) ?
					snake_game_pkg::FIELD_MIN : o_head_x + 1'b1;
			snake_game_pkg::HEAD_LEFT:
				nxt_x = (o_head_x <= snake_game_pkg::FIELD_MIN) ?
					snake_game_pkg::FIELD_MAX : o_head_x - 1'b1;
			// Screen rows grow downwards
			snake_game_pkg::HEAD_UP:
				nxt_y = (o_head_y <= snake_game_pkg::FIELD_MIN) ?
					snake_game_pkg::FIELD_MAX : o_head_y - 1'b1;
			default:
				nxt_y = (o_head_y >= snake_game_pkg::FIELD_MAX) ?
					snake_game_pkg::FIELD_MIN : o_head_y + 1'b1;
		endcase
	end

	assign hit_apple = (nxt_x == snake_game_pkg::APPLE_X) && (nxt_y == snake_game_pkg::APPLE_Y);
	assign o_grow = o_step && hit_apple;

	always_ff @(posedge i_clk_74M) begin
		if (i_rst) begin
			o_head_x <= snake_game_pkg::START_X;
			o_head_y <= snake_game_pkg::START_Y;
			o_score <= '0;
		end else if (o_step) begin
			o_head_x <= nxt_x;
			o_head_y <= nxt_y;
			if (hit_apple) begin
				o_score <= o_score + 1'b1;
			end
		end
	end

	a_head_in_field : assert property (@(posedge i_clk_74M) disable iff (i_rst)
		o_step |=> (o_head_x >= snake_game_pkg::FIELD_MIN &&
			o_head_x <= snake_game_pkg::FIELD_MAX &&
			o_head_y >= snake_game_pkg::FIELD_MIN &&
			o_head_y <= snake_game_pkg::FIELD_MAX))
		else $error("head left the play field");

	a_step_single : assert property (@(posedge i_clk_74M) disable iff (i_rst)
		(TICK_CYCLES > 1 && o_step) |=> !o_step)
		else $error("step strobe held for two cycles");

endmodule

// File: rtl/snake_body.sv
`timescale 1ns/10ps

module snake_body (
	input  logic                    i_clk_74M,
	input  logic                    i_rst,
	input  logic                    i_step,
	input  logic                    i_grow,
	input  snake_game_pkg::coord_t  i_head_x,
	input  snake_game_pkg::coord_t  i_head_y,
	input  snake_game_pkg::coord_t  i_tile_x,
	input  snake_game_pkg::coord_t  i_tile_y,
	output logic                    o_occupied
);

	// Segment 0 is the head itself, held in snake_motion
	snake_game_pkg::coord_t seg_x [1:snake_game_pkg::MAX_LEN-1];
	snake_game_pkg::coord_t seg_y [1:snake_game_pkg::MAX_LEN-1];
	snake_game_pkg::len_t   len;

	////////////////////////////////////////
	// Body shift
	////////////////////////////////////////

	// Head is sampled before its own update on the same edge
	always_ff @(posedge i_clk_74M) begin
		if (i_step) begin
			seg_x[1] <= i_head_x;
			seg_y[1] <= i_head_y;
			for (int i = 2; i < snake_game_pkg::MAX_LEN; i++) begin
				seg_x[i] <= seg_x[i-1];
				seg_y[i] <= seg_y[i-1];
			end
		end
	end

	// Visible length, saturating
	always_ff @(posedge i_clk_74M) begin
		if (i_rst) begin
			len <= snake_game_pkg::len_t'(1);
		end else if (i_grow && len != snake_game_pkg::len_t'(snake_game_pkg::MAX_LEN)) begin
			len <= len + 1'b1;
		end
	end

	////////////////////////////////////////
	// Occupancy of the scanned tile
	////////////////////////////////////////

	always_comb begin
		o_occupied = (i_tile_x == i_head_x) && (i_tile_y == i_head_y);
		for (int i = 1; i < snake_game_pkg::MAX_LEN; i++) begin
			if (i < len && seg_x[i] == i_tile_x && seg_y[i] == i_tile_y) begin
				o_occupied = 1'b1;
			end
		end
	end

endmodule

// File: rtl/tile_classify.sv
`timescale 1ns/10ps

module tile_classify (
	input  logic                              i_clk_74M,
	input  logic                              i_rst,
	input  logic [video_pkg::SCAN_W-1:0]      i_hcnt,
	input  logic [video_pkg::SCAN_W-1:0]      i_vcnt,
	input  logic                              i_occupied,
	output snake_game_pkg::coord_t            o_tile_x,
	output snake_game_pkg::coord_t            o_tile_y,
	output video_pkg::sprite_t                o_kind,
	output logic [video_pkg::TILE_BITS-1:0]   o_px,
	output logic [video_pkg::TILE_BITS-1:0]   o_py
);

	localparam int COORD_W = $bits(snake_game_pkg::coord_t);
	localparam int TOP_LSB = video_pkg::TILE_BITS + COORD_W;

	logic in_range;
	logic is_wall;
	logic is_apple;

	// Tile index sits above the pixel offset
	assign o_tile_x = i_hcnt[video_pkg::TILE_BITS +: COORD_W];
	assign o_tile_y = i_vcnt[video_pkg::TILE_BITS +: COORD_W];

	// Counts past the tile range must not alias back onto the grid
	assign in_range = (i_hcnt[video_pkg::SCAN_W-1:TOP_LSB] == '0) &&
		(i_vcnt[video_pkg::SCAN_W-1:TOP_LSB] == '0);

	assign is_wall = ((o_tile_y == snake_game_pkg::WALL_LO || o_tile_y == snake_game_pkg::WALL_HI) &&
			o_tile_x <= snake_game_pkg::WALL_HI) ||
		((o_tile_x == snake_game_pkg::WALL_LO || o_tile_x == snake_game_pkg::WALL_HI) &&
			o_tile_y <= snake_game_pkg::WALL_HI);

	assign is_apple = (o_tile_x == snake_game_pkg::APPLE_X) &&
		(o_tile_y == snake_game_pkg::APPLE_Y);

	////////////////////////////////////////
	// Stage 1 register
	////////////////////////////////////////

	// Wall over snake over apple
	always_ff @(posedge i_clk_74M) begin
		if (i_rst) begin
			o_kind <= video_pkg::SPR_NONE;
		end else if (!in_range) begin
			o_kind <= video_pkg::SPR_NONE;
		end else if (is_wall) begin
			o_kind <= video_pkg::SPR_WALL;
		end else if (i_occupied) begin
			o_kind <= video_pkg::SPR_SNAKE;
		end else if (is_apple) begin
			o_kind <= video_pkg::SPR_APPLE;
		end else begin
			o_kind <= video_pkg::SPR_NONE;
		end
	end

	always_ff @(posedge i_clk_74M) begin
		o_px <= i_hcnt[video_pkg::TILE_BITS-1:0];
		o_py <= i_vcnt[video_pkg::TILE_BITS-1:0];
	end

endmodule

// File: rtl/sprite_rom.sv
`timescale 1ns/10ps

module sprite_rom (
	input  logic                              i_clk_74M,
	input  logic                              i_rst,
	input  video_pkg::sprite_t                i_kind,
	input  logic [video_pkg::TILE_BITS-1:0]   i_px,
	input  logic [video_pkg::TILE_BITS-1:0]   i_py,
	output video_pkg::chan_t                  o_r,
	output video_pkg::chan_t                  o_g,
	output video_pkg::chan_t                  o_b
);

	video_pkg::rgb_t fill;
	video_pkg::rgb_t pixel;
	logic            border;

	// One pixel frame around each tile
	assign border = (i_px == '0) || (i_px == '1) || (i_py == '0) || (i_py == '1);

	always_comb begin
		case (i_kind)
			video_pkg::SPR_WALL:  fill = video_pkg::WALL_FILL;
			video_pkg::SPR_SNAKE: fill = video_pkg::SNAKE_FILL;
			video_pkg::SPR_APPLE: fill = video_pkg::APPLE_FILL;
			default:              fill = video_pkg::BLACK;
		endcase
	end

	// Darker outline
	assign pixel = border ? {(fill.r >> 1), (fill.g >> 1), (fill.b >> 1)} : fill;

	always_ff @(posedge i_clk_74M) begin
		if (i_rst) begin
			o_r <= '0;
			o_g <= '0;
			o_b <= '0;
		end else begin
			o_r <= pixel.r;
			o_g <= pixel.g;
			o_b <= pixel.b;
		end
	end

	a_none_is_black : assert property (@(posedge i_clk_74M) disable iff (i_rst)
		(i_kind == video_pkg::SPR_NONE) |=> (o_r == '0 && o_g == '0 && o_b == '0))
		else $error("background pixel not black");

endmodule

// File: rtl/snake_top.sv
`timescale 1ns/10ps

module snake_top #(
	parameter int TICK_CYCLES = snake_game_pkg::TICK_DEFAULT
) (
	input  logic                          i_clk_74M,
	input  logic                          i_rst,
	input  logic [video_pkg::SCAN_W-1:0]  i_hcnt,
	input  logic [video_pkg::SCAN_W-1:0]  i_vcnt,
	input  logic                          i_btn_right,
	input  logic                          i_btn_left,
	input  logic                          i_btn_up,
	input  logic                          i_btn_down,
	output video_pkg::chan_t              o_r,
	output video_pkg::chan_t              o_g,
	output video_pkg::chan_t              o_b,
	output snake_game_pkg::score_t        o_score
);

	snake_game_pkg::heading_t              heading;
	snake_game_pkg::coord_t                head_x;
	snake_game_pkg::coord_t                head_y;
	logic                                  step;
	logic                                  grow;
	snake_game_pkg::coord_t                tile_x;
	snake_game_pkg::coord_t                tile_y;
	logic                                  occupied;
	video_pkg::sprite_t                    kind;
	logic [video_pkg::TILE_BITS-1:0]       px;
	logic [video_pkg::TILE_BITS-1:0]       py;

	////////////////////////////////////////
	// Game state
	////////////////////////////////////////

	heading_control u_heading (
		.i_clk_74M   (i_clk_74M),
		.i_rst       (i_rst),
		.i_btn_right (i_btn_right),
		.i_btn_left  (i_btn_left),
		.i_btn_up    (i_btn_up),
		.i_btn_down  (i_btn_down),
		.o_heading   (heading)
	);

	snake_motion #(
		.TICK_CYCLES (TICK_CYCLES)
	) u_motion (
		.i_clk_74M (i_clk_74M),
		.i_rst     (i_rst),
		.i_heading (heading),
		.o_head_x  (head_x),
		.o_head_y  (head_y),
		.o_step    (step),
		.o_grow    (grow),
		.o_score   (o_score)
	);

	snake_body u_body (
		.i_clk_74M  (i_clk_74M),
		.i_rst      (i_rst),
		.i_step     (step),
		.i_grow     (grow),
		.i_head_x   (head_x),
		.i_head_y   (head_y),
		.i_tile_x   (tile_x),
		.i_tile_y   (tile_y),
		.o_occupied (occupied)
	);

	////////////////////////////////////////
	// Pixel pipeline
	////////////////////////////////////////

	tile_classify u_classify (
		.i_clk_74M  (i_clk_74M),
		.i_rst      (i_rst),
		.i_hcnt     (i_hcnt),
		.i_vcnt     (i_vcnt),
		.i_occupied (occupied),
		.o_tile_x   (tile_x),
		.o_tile_y   (tile_y),
		.o_kind     (kind),
		.o_px       (px),
		.o_py       (py)
	);

	sprite_rom u_sprite (
		.i_clk_74M (i_clk_74M),
		.i_rst     (i_rst),
		.i_kind    (kind),
		.i_px      (px),
		.i_py      (py),
		.o_r       (o_r),
		.o_g       (o_g),
		.o_b       (o_b)
	);

endmodule

// File: testbench/tb_snake_model.svh
`ifndef TB_SNAKE_MODEL_SVH
`define TB_SNAKE_MODEL_SVH

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// Only perpendicular turns, right before left and down before up
function automatic snake_game_pkg::heading_t turn_heading(
	input snake_game_pkg::heading_t cur,
	input logic right,
	input logic left,
	input logic up,
	input logic down
);
	snake_game_pkg::heading_t nxt;
	nxt = cur;
	if (cur == snake_game_pkg::HEAD_UP || cur == snake_game_pkg::HEAD_DOWN) begin
		if (right) begin
			nxt = snake_game_pkg::HEAD_RIGHT;
		end else if (left) begin
			nxt = snake_game_pkg::HEAD_LEFT;
		end
	end else begin
		if (down) begin
			nxt = snake_game_pkg::HEAD_DOWN;
		end else if (up) begin
			nxt = snake_game_pkg::HEAD_UP;
		end
	end
	return nxt;
endfunction

function automatic snake_game_pkg::coord_t next_x(
	input snake_game_pkg::heading_t hd,
	input snake_game_pkg::coord_t x
);
	if (hd == snake_game_pkg::HEAD_RIGHT) begin
		return (x == snake_game_pkg::FIELD_MAX) ? snake_game_pkg::FIELD_MIN : x + 6'd1;
	end else if (hd == snake_game_pkg::HEAD_LEFT) begin
		return (x == snake_game_pkg::FIELD_MIN) ? snake_game_pkg::FIELD_MAX : x - 6'd1;
	end
	return x;
endfunction

// Up means a smaller row number on screen
function automatic snake_game_pkg::coord_t next_y(
	input snake_game_pkg::heading_t hd,
	input snake_game_pkg::coord_t y
);
	if (hd == snake_game_pkg::HEAD_DOWN) begin
		return (y == snake_game_pkg::FIELD_MAX) ? snake_game_pkg::FIELD_MIN : y + 6'd1;
	end else if (hd == snake_game_pkg::HEAD_UP) begin
		return (y == snake_game_pkg::FIELD_MIN) ? snake_game_pkg::FIELD_MAX : y - 6'd1;
	end
	return y;
endfunction

function automatic video_pkg::sprite_t tile_kind(
	input snake_game_pkg::coord_t tx,
	input snake_game_pkg::coord_t ty,
	input logic occ
);
	logic wall_row;
	logic wall_col;
	wall_row = (ty == snake_game_pkg::WALL_LO || ty == snake_game_pkg::WALL_HI) && tx <= 6'd14;
	wall_col = (tx == snake_game_pkg::WALL_LO || tx == snake_game_pkg::WALL_HI) && ty <= 6'd14;
	if (wall_row || wall_col) begin
		return video_pkg::SPR_WALL;
	end else if (occ) begin
		return video_pkg::SPR_SNAKE;
	end else if (tx == snake_game_pkg::APPLE_X && ty == snake_game_pkg::APPLE_Y) begin
		return video_pkg::SPR_APPLE;
	end
	return video_pkg::SPR_NONE;
endfunction

function automatic video_pkg::rgb_t pixel_colour(
	input video_pkg::sprite_t kind,
	input logic [4:0] px,
	input logic [4:0] py
);
	video_pkg::rgb_t fill;
	video_pkg::rgb_t colour;
	case (kind)
		video_pkg::SPR_WALL:  fill = video_pkg::WALL_FILL;
		video_pkg::SPR_SNAKE: fill = video_pkg::SNAKE_FILL;
		video_pkg::SPR_APPLE: fill = video_pkg::APPLE_FILL;
		default:              fill = '0;
	endcase
	colour = fill;
	// Outline is one pixel wide and half as bright
	if (px == 5'd0 || px == 5'd31 || py == 5'd0 || py == 5'd31) begin
		colour.r = fill.r >> 1;
		colour.g = fill.g >> 1;
		colour.b = fill.b >> 1;
	end
	return colour;
endfunction

`endif

// File: testbench/tb_snake_top.sv
`timescale 1ns/10ps

module tb_snake_top;

	localparam int TICK_CYCLES = 8;
	localparam int N_ENTRIES = 10;
	localparam int LAP_FIRST = 7;
	localparam int LAPS = 17;

	// Button bits are right, left, up, down
	localparam logic [3:0] BTN_NONE  = 4'b0000;
	localparam logic [3:0] BTN_LEFT  = 4'b0100;
	localparam logic [3:0] BTN_UP    = 4'b0010;
	localparam logic [3:0] BTN_DOWN  = 4'b0001;

	logic                          i_clk_74M;
	logic                          i_rst;
	logic [video_pkg::SCAN_W-1:0]  i_hcnt;
	logic [video_pkg::SCAN_W-1:0]  i_vcnt;
	logic                          i_btn_right;
	logic                          i_btn_left;
	logic                          i_btn_up;
	logic                          i_btn_down;
	video_pkg::chan_t              o_r;
	video_pkg::chan_t              o_g;
	video_pkg::chan_t              o_b;
	snake_game_pkg::score_t        o_score;

	logic [3:0] tbl_btn [N_ENTRIES];
	int         tbl_steps [N_ENTRIES];

	snake_game_pkg::heading_t  m_heading;
	snake_game_pkg::coord_t    m_x;
	snake_game_pkg::coord_t    m_y;
	snake_game_pkg::coord_t    m_seg_x [1:snake_game_pkg::MAX_LEN];
	snake_game_pkg::coord_t    m_seg_y [1:snake_game_pkg::MAX_LEN];
	int                        m_len;
	int                        m_tick;
	int                        m_steps;
	snake_game_pkg::score_t    m_score;

	logic [3:0]             btn;
	logic                   pix_valid;
	snake_game_pkg::coord_t pix_tx;
	snake_game_pkg::coord_t pix_ty;
	logic [4:0]             pix_px;
	logic [4:0]             pix_py;
	logic                   exp_valid;
	video_pkg::rgb_t        exp_rgb;
	int                     scan_idx;
	int                     errors;
	int                     checks;
	int                     cycles;
	int                     cycle_limit;

	initial i_clk_74M = 1'b0;
	always #2 i_clk_74M = ~i_clk_74M;

	snake_top #(
		.TICK_CYCLES (TICK_CYCLES)
	) uut (
		.i_clk_74M   (i_clk_74M),
		.i_rst       (i_rst),
		.i_hcnt      (i_hcnt),
		.i_vcnt      (i_vcnt),
		.i_btn_right (i_btn_right),
		.i_btn_left  (i_btn_left),
		.i_btn_up    (i_btn_up),
		.i_btn_down  (i_btn_down),
		.o_r         (o_r),
		.o_g         (o_g),
		.o_b         (o_b),
		.o_score     (o_score)
	);

	`include "tb_snake_model.svh"

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic occupied_at(input snake_game_pkg::coord_t tx,
		input snake_game_pkg::coord_t ty);
		logic occ;
		occ = (tx == m_x) && (ty == m_y);
		for (int i = 1; i < m_len; i++) begin
			if (m_seg_x[i] == tx && m_seg_y[i] == ty) begin
				occ = 1'b1;
			end
		end
		return occ;
	endfunction

	// Bias towards the outline pixels
	function automatic logic [4:0] rand_offset();
		int unsigned sel;
		sel = $urandom % 4;
		if (sel == 0) begin
			return 5'd0;
		end else if (sel == 1) begin
			return 5'd31;
		end
		return 5'($urandom % 32);
	endfunction

	task automatic check(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, expected, $time);
			errors++;
		end
	endtask

	// Game state change on one rising edge
	task automatic advance_model();
		snake_game_pkg::coord_t nx;
		snake_game_pkg::coord_t ny;
		if (m_tick == TICK_CYCLES - 1) begin
			m_tick = 0;
			for (int i = snake_game_pkg::MAX_LEN; i > 1; i--) begin
				m_seg_x[i] = m_seg_x[i-1];
				m_seg_y[i] = m_seg_y[i-1];
			end
			m_seg_x[1] = m_x;
			m_seg_y[1] = m_y;
			nx = next_x(m_heading, m_x);
			ny = next_y(m_heading, m_y);
			m_x = nx;
			m_y = ny;
			if (nx == snake_game_pkg::APPLE_X && ny == snake_game_pkg::APPLE_Y) begin
				m_score++;
				if (m_len < snake_game_pkg::MAX_LEN) begin
					m_len++;
				end
			end
			m_steps++;
		end else begin
			m_tick++;
		end
		m_heading = turn_heading(m_heading, i_btn_right, i_btn_left, i_btn_up, i_btn_down);
	endtask

	// Head, body, tail, tile past the tail, apple, wall, random, fixed
	task automatic pick_scan();
		int unsigned w;
		case (scan_idx)
			0: begin
				pix_tx = m_x;
				pix_ty = m_y;
			end
			1: begin
				pix_tx = m_seg_x[1];
				pix_ty = m_seg_y[1];
			end
			2: begin
				pix_tx = m_seg_x[m_len];
				pix_ty = m_seg_y[m_len];
			end
			3: begin
				pix_tx = (m_len > 1) ? m_seg_x[m_len-1] : m_x;
				pix_ty = (m_len > 1) ? m_seg_y[m_len-1] : m_y;
			end
			4: begin
				pix_tx = snake_game_pkg::APPLE_X;
				pix_ty = snake_game_pkg::APPLE_Y;
			end
			5: begin
				w = $urandom % 5;
				pix_tx = (w == 4) ? 6'd14 : ((w[0]) ? 6'd14 : 6'd0);
				pix_ty = (w == 4) ? 6'd7 : ((w[1]) ? 6'd14 : 6'd0);
			end
			6: begin
				pix_tx = 6'($urandom % 16);
				pix_ty = 6'($urandom % 16);
			end
			default: begin
				pix_tx = 6'd7;
				pix_ty = 6'd7;
			end
		endcase
		// Tile interiors while the head still sits on START
		if (m_steps == 0) begin
			pix_px = 5'd16;
			pix_py = 5'd16;
		end else begin
			pix_px = rand_offset();
			pix_py = rand_offset();
		end
		scan_idx = (scan_idx + 1) % 8;
	endtask

	task automatic run_cycle();
		@(posedge i_clk_74M);
		#0.5;
		if (exp_valid) begin
			check("o_r", o_r, exp_rgb.r);
			check("o_g", o_g, exp_rgb.g);
			check("o_b", o_b, exp_rgb.b);
		end
		// Pixel presented before this edge was classified on pre-edge state
		exp_valid = pix_valid;
		exp_rgb = pixel_colour(tile_kind(pix_tx, pix_ty, occupied_at(pix_tx, pix_ty)),
			pix_px, pix_py);
		advance_model();
		check("o_score", o_score, m_score);
		pick_scan();
		i_hcnt = {1'b0, pix_tx, pix_px};
		i_vcnt = {1'b0, pix_ty, pix_py};
		pix_valid = 1'b1;
		{i_btn_right, i_btn_left, i_btn_up, i_btn_down} = btn;
	endtask

	task automatic apply_entry(input int e);
		int target;
		btn = tbl_btn[e];
		target = m_steps + tbl_steps[e];
		while (m_steps < target) begin
			run_cycle();
		end
	endtask

	////////////////////////////////////////
	// Timeout
	////////////////////////////////////////

	always @(posedge i_clk_74M) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		int total_steps;
		void'($urandom(13));
		// Wrap right, down, left and up, then laps through the apple
		tbl_btn[0] = BTN_LEFT;
		tbl_steps[0] = 3;
		tbl_btn[1] = BTN_NONE;
		tbl_steps[1] = 10;
		tbl_btn[2] = BTN_DOWN;
		tbl_steps[2] = 3;
		tbl_btn[3] = BTN_UP;
		tbl_steps[3] = 2;
		tbl_btn[4] = BTN_LEFT;
		tbl_steps[4] = 2;
		tbl_btn[5] = BTN_UP;
		tbl_steps[5] = 7;
		tbl_btn[6] = BTN_LEFT;
		tbl_steps[6] = 3;
		tbl_btn[7] = BTN_LEFT;
		tbl_steps[7] = 6;
		tbl_btn[8] = BTN_DOWN;
		tbl_steps[8] = 13;
		tbl_btn[9] = BTN_LEFT;
		tbl_steps[9] = 7;
		total_steps = 0;
		for (int e = 0; e < N_ENTRIES; e++) begin
			total_steps += (e < LAP_FIRST) ? tbl_steps[e] : LAPS * tbl_steps[e];
		end
		cycle_limit = total_steps * TICK_CYCLES * 16 + 1000;
		cycles = 0;
		errors = 0;
		checks = 0;
		scan_idx = 0;
		i_rst = 1'b1;
		i_hcnt = '0;
		i_vcnt = '0;
		i_btn_right = 1'b0;
		i_btn_left = 1'b0;
		i_btn_up = 1'b0;
		i_btn_down = 1'b0;
		btn = BTN_NONE;
		// Stage 1 reset kind first, then the count held during reset
		exp_valid = 1'b1;
		exp_rgb = '0;
		pix_valid = 1'b1;
		pix_tx = '0;
		pix_ty = '0;
		pix_px = '0;
		pix_py = '0;
		m_heading = snake_game_pkg::HEAD_RIGHT;
		m_x = snake_game_pkg::START_X;
		m_y = snake_game_pkg::START_Y;
		for (int i = 1; i <= snake_game_pkg::MAX_LEN; i++) begin
			m_seg_x[i] = '0;
			m_seg_y[i] = '0;
		end
		m_len = 1;
		m_tick = 0;
		m_steps = 0;
		m_score = '0;
		repeat (2) @(posedge i_clk_74M);
		#0.5;
		i_rst = 1'b0;
		check("o_r", o_r, 0);
		check("o_g", o_g, 0);
		check("o_b", o_b, 0);
		check("o_score", o_score, 0);
		for (int e = 0; e < LAP_FIRST; e++) begin
			apply_entry(e);
		end
		for (int lap = 0; lap < LAPS; lap++) begin
			for (int e = LAP_FIRST; e < N_ENTRIES; e++) begin
				apply_entry(e);
			end
		end
		// Drain the pixel pipeline
		repeat (3) run_cycle();
		// One apple on the approach, one per lap
		check("o_score", o_score, LAPS + 1);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+testbench
rtl/snake_game_pkg.sv
rtl/video_pkg.sv
rtl/heading_control.sv
rtl/snake_motion.sv
rtl/snake_body.sv
rtl/tile_classify.sv
rtl/sprite_rom.sv
rtl/snake_top.sv
testbench/tb_snake_top.sv
